// File: src.f
verilog/ellipse_pkg.sv
verilog/ellipse_control.sv
verilog/ellipse_setup.sv
verilog/ellipse_arc_stepper.sv
verilog/quadrant_mapper.sv
verilog/ellipse_generator.sv
dv/ellipse_generator_tb.sv

// File: dv/ellipse_generator_tb.sv
// quarter-ellipse rasterizer testbench
// directed tests against a software model of the midpoint recurrences,
// covering the point command, quadrant mirroring, tiny radii, random pause
// and an enable hold in the middle of a drawing
`default_nettype none

module ellipse_generator_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import ellipse_pkg::*;

  logic        clk;
  logic        reset;
  logic        enable;
  logic        run;
  logic        ena_pause;
  logic [1:0]  quadrant;
  coord_t      xc, yc, xr, yr;
  logic        busy;
  logic        pixel_data_rdy;
  logic        ellipse_complete;
  coord_t      x_coord, y_coord;
  int          exp_x[$], exp_y[$];  // model pixels, in order
  int          got_x[$], got_y[$];  // pixels taken from the DUT
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  longint      budget = 1000;       // watchdog limit in cycles, grows per command
  logic        pause_on;
  logic [31:0] rng;

  ellipse_generator ellipse_generator_inst (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // screen x always takes the bit 0 sign, screen y the bit 1 sign
  function automatic void add_pixel(input longint lx, input longint ly, input bit second,
                                    input logic [1:0] q, input int x0, input int y0);
    longint dx;
    longint dy;
    dx = second ? ly : lx;  // second half steps along the other axis
    dy = second ? lx : ly;
    exp_x.push_back(q[0] ? x0 - dx : x0 + dx);
    exp_y.push_back(q[1] ? y0 - dy : y0 + dy);
  endfunction

  function automatic void model_half(input longint rmaj, input longint rmin, input bit second,
                                     input logic [1:0] q, input int x0, input int y0);
    longint x, y, p, px, py, rx2, ry2;
    bit     started;
    rx2 = rmaj * rmaj;
    ry2 = rmin * rmin;
    p = (rx2 + 2) / 4 + ry2 - rx2 * rmin;  // rounded quarter of rx2
    py = 2 * rx2 * rmin;
    px = 0;
    x = 0;
    y = rmin;
    started = 0;
    if (rmaj >= 2) begin
      while (px <= py) begin
        add_pixel(x, y, second, q, x0, y0);
        x++;
        px += 2 * ry2;
        if (p <= 0) begin
          p += ry2 + px;
        end else begin
          y--;
          py -= 2 * rx2;
          p += ry2 + px - py;
        end
      end
    end
    while (((y < 2) || started) && (x <= rmaj)) begin
      if (started) begin
        add_pixel(x, 0, second, q, x0, y0);
        x++;
      end else begin
        started = 1;  // first flat cycle only clears y
        y = 0;
      end
    end
  endfunction

  function automatic void expect_command(input int x0, input int y0, input int rx,
                                         input int ry, input logic [1:0] q);
    if (rx == 0 && ry == 0) begin
      exp_x.push_back(x0);
      exp_y.push_back(y0);
    end else begin
      model_half(rx, ry, 1'b0, q, x0, y0);
      model_half(ry, rx, 1'b1, q, x0, y0);  // centre and radii swapped
    end
    budget += 200 * exp_x.size() + 300;
  endfunction

  task automatic check_equal(input string what, input logic signed [63:0] got,
                             input logic signed [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic start_command(input int x0, input int y0, input int rx, input int ry,
                               input logic [1:0] q, input bit measure);
    int lat;
    expect_command(x0, y0, rx, ry, q);
    @(posedge clk);
    run      <= 1'b1;
    xc       <= coord_t'(x0);
    yc       <= coord_t'(y0);
    xr       <= coord_t'(rx);
    yr       <= coord_t'(ry);
    quadrant <= q;
    @(posedge clk);  // accepted on this edge, idle and step high
    run <= 1'b0;
    lat = 1;
    @(negedge clk);
    check_equal("busy after accept", busy, 1);
    if (measure) begin
      while (!pixel_data_rdy) begin
        @(posedge clk);
        lat++;
        @(negedge clk);
      end
      check_equal("first pixel latency", lat, 9);  // latch, 6 setup, load, mapper
    end
  endtask

  task automatic compare_pixels(input string name);
    int n;
    check_equal({name, " pixel count"}, got_x.size(), exp_x.size());
    n = (got_x.size() < exp_x.size()) ? got_x.size() : exp_x.size();
    for (int i = 0; i < n; i++) begin
      check_equal($sformatf("%s pixel %0d x", name, i), got_x[i], exp_x[i]);
      check_equal($sformatf("%s pixel %0d y", name, i), got_y[i], exp_y[i]);
    end
    got_x.delete();
    got_y.delete();
    exp_x.delete();
    exp_y.delete();
  endtask

  task automatic finish_command(input string name);
    do @(negedge clk); while (!ellipse_complete);
    check_equal({name, " busy at complete"}, busy, 0);
    @(negedge clk);
    check_equal({name, " complete width"}, ellipse_complete, 0);  // one-shot
    compare_pixels(name);
  endtask

  task automatic point_test();
    start_command(120, 80, 0, 0, 2'd0, 1'b0);  // centre point only
    finish_command("point");
  endtask

  task automatic quadrant_zero_test();
    start_command(300, 250, 9, 5, 2'd0, 1'b1);
    finish_command("quadrant 0");
  endtask

  task automatic quadrant_sweep_test();
    for (int q = 0; q < 4; q++) begin
      start_command(100, 200, 9, 5, q[1:0], 1'b0);
      finish_command($sformatf("quadrant sweep %0d", q));
    end
  endtask

  task automatic small_radius_test();
    start_command(60, 70, 1, 1, 2'd1, 1'b0);  // flat edge only
    finish_command("small radius");
  endtask

  task automatic random_pause_test();
    @(posedge clk);
    pause_on <= 1'b1;
    start_command(300, 250, 9, 5, 2'd0, 1'b0);
    finish_command("random pause");
    @(posedge clk);
    pause_on <= 1'b0;
    @(posedge clk);
  endtask

  task automatic enable_hold_test();
    coord_t hx;
    coord_t hy;
    logic   hr;
    start_command(500, 400, 12, 7, 2'd3, 1'b0);
    while (got_x.size() < 6) @(negedge clk);
    @(posedge clk);
    enable <= 1'b0;
    @(negedge clk);
    hx = x_coord;
    hy = y_coord;
    hr = pixel_data_rdy;
    repeat (20) begin
      @(negedge clk);
      check_equal("held x_coord", x_coord, hx);
      check_equal("held y_coord", y_coord, hy);
      check_equal("held pixel_data_rdy", pixel_data_rdy, hr);
      check_equal("complete while disabled", ellipse_complete, 0);
    end
    @(posedge clk);
    enable <= 1'b1;
    finish_command("enable hold");
  endtask

  // a pixel is consumed on an edge where it is ready and the step runs
  always @(negedge clk) begin
    if (!reset && enable && pixel_data_rdy) begin
      got_x.push_back(x_coord);
      got_y.push_back(y_coord);
    end
    if (!reset && ena_pause) check_equal("pixel_data_rdy under pause", pixel_data_rdy, 0);
  end

  always @(posedge clk) begin
    if (pause_on) begin
      rng = lcg_next(rng);
      ena_pause <= rng[16];  // bit 16 pauses about half the cycles
    end else begin
      ena_pause <= 1'b0;
    end
  end

  initial begin
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles > budget) begin
        $display("Timeout: no ellipse_complete within %0d cycles", cycles);
        $display("checks %0d, errors %0d", checks, errors);
        $display("Test failed");
        $finish;
      end
    end
  end

  initial begin
    reset     = 1'b1;
    enable    = 1'b0;
    run       = 1'b0;
    ena_pause = 1'b0;
    quadrant  = 2'd0;
    xc        = '0;
    yc        = '0;
    xr        = '0;
    yr        = '0;
    pause_on  = 1'b0;
    rng       = 32'hbbde93a5;
    repeat (8) @(posedge clk);
    reset  <= 1'b0;
    enable <= 1'b1;
    @(negedge clk);
    check_equal("busy after reset", busy, 0);
    check_equal("pixel_data_rdy after reset", pixel_data_rdy, 0);
    check_equal("complete after reset", ellipse_complete, 0);
    point_test();
    quadrant_zero_test();
    quadrant_sweep_test();
    small_radius_test();
    random_pause_test();
    enable_hold_test();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/ellipse_generator.sv
// quarter-ellipse rasterizer, top level
// qualifies the process step with enable and pause, combines busy,
// and connects control, setup, stepper and mapper
`default_nettype none

module ellipse_generator (
  input  logic                clk,
  input  logic                reset,
  input  logic                enable,
  input  logic                run,
  input  logic                ena_pause,
  input  logic [1:0]          quadrant,
  input  ellipse_pkg::coord_t xc,
  input  ellipse_pkg::coord_t yc,
  input  ellipse_pkg::coord_t xr,
  input  ellipse_pkg::coord_t yr,
  output logic                busy,
  output logic                pixel_data_rdy,
  output logic                ellipse_complete,
  output ellipse_pkg::coord_t x_coord,
  output ellipse_pkg::coord_t y_coord
);
  import ellipse_pkg::*;

  logic       step;         // process enable for every register
  logic       valid_int;    // pixel held at the output
  logic       busy_reg;
  logic       start_setup;
  logic       setup_done;
  logic       start_arc;
  logic       half_done;
  logic       point_valid;
  logic       pix_valid;
  logic       half;         // second half, axes swapped
  logic [1:0] quad;
  coord_t     cx, cy;       // active centre
  coord_t     rmaj, rmin;   // active radii
  coord_t     lx, ly;       // local offsets from the stepper
  sq_t        rx2, ry2;
  err_t       p0, py0;

  assign step = enable && !(ena_pause && valid_int);  // freeze while a pixel waits
  assign busy = busy_reg || run;

  ellipse_control ellipse_control_inst (
    .clk, .reset, .step, .run, .quadrant,
    .xc, .yc, .xr, .yr,
    .setup_done, .half_done,
    .start_setup, .start_arc, .point_valid, .half, .busy_reg, .ellipse_complete,
    .quad, .cx, .cy, .rmaj, .rmin
  );

  ellipse_setup ellipse_setup_inst (
    .clk, .reset, .step, .start_setup,
    .rmaj, .rmin,
    .setup_done, .rx2, .ry2, .p0, .py0
  );

  ellipse_arc_stepper ellipse_arc_stepper_inst (
    .clk, .reset, .step, .start_arc,
    .rmaj, .rmin, .rx2, .ry2, .p0, .py0,
    .lx, .ly, .pix_valid, .half_done
  );

  quadrant_mapper quadrant_mapper_inst (
    .clk, .reset, .step, .ena_pause, .pix_valid, .point_valid, .half,
    .quad, .cx, .cy, .lx, .ly,
    .x_coord, .y_coord, .pixel_data_rdy, .valid_int
  );

  // a pixel waiting on a paused sink stays on the outputs unchanged
  pause_holds_pixel: assert property (@(posedge clk) disable iff (reset)
    ena_pause && valid_int |=> valid_int && $stable(x_coord) && $stable(y_coord));

endmodule

`default_nettype wire

// File: verilog/quadrant_mapper.sv
// quadrant mapper
// mirrors the local offsets into the latched quadrant, swaps the axes
// for the second half, registers the pixel and gates ready with pause
`default_nettype none

module quadrant_mapper (
  input  logic                clk,
  input  logic                reset,
  input  logic                step,
  input  logic                ena_pause,
  input  logic                pix_valid,
  input  logic                point_valid,
  input  logic                half,
  input  logic [1:0]          quad,
  input  ellipse_pkg::coord_t cx,
  input  ellipse_pkg::coord_t cy,
  input  ellipse_pkg::coord_t lx,
  input  ellipse_pkg::coord_t ly,
  output ellipse_pkg::coord_t x_coord,
  output ellipse_pkg::coord_t y_coord,
  output logic                pixel_data_rdy,
  output logic                valid_int
);
  import ellipse_pkg::*;

  coord_t off_x;   // local x, zero for the centre point
  coord_t off_y;   // local y, zero for the centre point
  coord_t a_term;  // centre a plus or minus x offset
  coord_t b_term;  // centre b plus or minus y offset
  logic   neg_a;
  logic   neg_b;

  assign off_x  = point_valid ? '0 : lx;
  assign off_y  = point_valid ? '0 : ly;
  assign neg_a  = half ? quad[1] : quad[0];  // in the second half a lands on screen y
  assign neg_b  = half ? quad[0] : quad[1];
  assign a_term = neg_a ? cx - off_x : cx + off_x;
  assign b_term = neg_b ? cy - off_y : cy + off_y;

  assign pixel_data_rdy = valid_int && !ena_pause;  // drops at once on pause

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      x_coord   <= '0;
      y_coord   <= '0;
      valid_int <= 1'b0;
    end else if (step) begin
      x_coord   <= half ? b_term : a_term;
      y_coord   <= half ? a_term : b_term;
      valid_int <= pix_valid || point_valid;
    end
  end

endmodule

`default_nettype wire

// File: verilog/ellipse_arc_stepper.sv
// midpoint arc stepper
// walks local x and y along one half of the quadrant with the integer
// midpoint recurrences, then along the trailing flat edge near the axis
`default_nettype none

module ellipse_arc_stepper (
  input  logic                clk,
  input  logic                reset,
  input  logic                step,
  input  logic                start_arc,
  input  ellipse_pkg::coord_t rmaj,
  input  ellipse_pkg::coord_t rmin,
  input  ellipse_pkg::sq_t    rx2,
  input  ellipse_pkg::sq_t    ry2,
  input  ellipse_pkg::err_t   p0,
  input  ellipse_pkg::err_t   py0,
  output ellipse_pkg::coord_t lx,
  output ellipse_pkg::coord_t ly,
  output logic                pix_valid,
  output logic                half_done
);
  import ellipse_pkg::*;

  err_t p;          // decision term
  err_t px;         // x slope accumulator
  err_t py;         // y slope accumulator
  err_t px_next;    // px after an x step
  err_t py_next;    // py after a y step
  err_t p_next;     // decision term after this pixel
  logic arc_act;    // walking the arc
  logic flat_act;   // walking the flat edge
  logic draw_flat;  // y already cleared, flat pixels flow
  logic arc_emit;   // arc pixel this cycle
  logic flat_go;    // flat edge still has pixels left

  assign px_next = px + (err_t'(ry2) <<< 1);
  assign py_next = py - (err_t'(rx2) <<< 1);
  assign p_next  = (p <= 0) ? p + err_t'(ry2) + px_next
                            : p + err_t'(ry2) + px_next - py_next;

  assign arc_emit  = arc_act && (px <= py);              // slope still below one
  assign flat_go   = ((ly < 2) || draw_flat) && (lx <= rmaj);
  assign pix_valid = arc_emit || (flat_act && flat_go && draw_flat);
  assign half_done = flat_act && !flat_go;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      lx        <= '0;
      ly        <= '0;
      p         <= '0;
      px        <= '0;
      py        <= '0;
      arc_act   <= 1'b0;
      flat_act  <= 1'b0;
      draw_flat <= 1'b0;
    end else if (step) begin
      if (start_arc) begin
        lx        <= '0;
        ly        <= rmin;
        p         <= p0;
        px        <= '0;
        py        <= py0;
        draw_flat <= 1'b0;
        arc_act   <= (rmaj >= 2);  // tiny radius has no arc to speak of
        flat_act  <= (rmaj < 2);
      end else if (arc_act) begin
        if (arc_emit) begin
          lx <= lx + 1'b1;
          px <= px_next;
          p  <= p_next;
          if (p > 0) begin
            ly <= ly - 1'b1;  // midpoint outside, step inward
            py <= py_next;
          end
        end else begin
          arc_act  <= 1'b0;   // idle cycle at the hand-over
          flat_act <= 1'b1;
        end
      end else if (flat_act) begin
        if (flat_go) begin
          draw_flat <= 1'b1;
          ly        <= '0;    // first flat cycle only settles y
          if (draw_flat) lx <= lx + 1'b1;
        end else begin
          flat_act <= 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/ellipse_setup.sv
// ellipse setup datapath
// one registered multiplier shared over six steps computes the squared
// radii, the initial decision term p0 and the initial slope term py0
`default_nettype none

module ellipse_setup (
  input  logic                clk,
  input  logic                reset,
  input  logic                step,
  input  logic                start_setup,
  input  ellipse_pkg::coord_t rmaj,
  input  ellipse_pkg::coord_t rmin,
  output logic                setup_done,
  output ellipse_pkg::sq_t    rx2,
  output ellipse_pkg::sq_t    ry2,
  output ellipse_pkg::err_t   p0,
  output ellipse_pkg::err_t   py0
);
  import ellipse_pkg::*;

  rad_t                op_a;       // multiplier operand a
  sq_t                 op_b;       // multiplier operand b
  prod_t               prod;       // registered product, one step behind the operands
  sq_t                 quarter;    // rx2/4 rounded
  err_t                acc;        // p0 being built
  logic [2:0]          phase;      // 0 when idle, 2..6 for the remaining steps
  logic [2*RAD_BITS:0] round_sum;  // rx2 + 2, one bit wider

  assign round_sum = {1'b0, prod[2*RAD_BITS-1:0]} + (2*RAD_BITS+1)'(2);

  // shared multiplier
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      prod <= '0;
    end else if (step) begin
      prod <= op_a * op_b;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      op_a       <= '0;
      op_b       <= '0;
      quarter    <= '0;
      acc        <= '0;
      phase      <= 3'd0;
      setup_done <= 1'b0;
      rx2        <= '0;
      ry2        <= '0;
      p0         <= '0;
      py0        <= '0;
    end else if (step) begin
      setup_done <= 1'b0;
      if (start_setup) begin
        op_a  <= rmaj[RAD_BITS-1:0];        // step 1, rmaj * rmaj
        op_b  <= sq_t'(rmaj[RAD_BITS-1:0]);
        phase <= 3'd2;
      end else begin
        case (phase)
          3'd2: begin
            op_a  <= rmin[RAD_BITS-1:0];    // rmin * rmin
            op_b  <= sq_t'(rmin[RAD_BITS-1:0]);
            phase <= 3'd3;
          end
          3'd3: begin
            rx2     <= prod[2*RAD_BITS-1:0];  // rmaj squared is out
            op_a    <= rmin[RAD_BITS-1:0];    // rmin * rx2
            op_b    <= prod[2*RAD_BITS-1:0];
            quarter <= sq_t'(round_sum >> 2);
            phase   <= 3'd4;
          end
          3'd4: begin
            ry2   <= prod[2*RAD_BITS-1:0];    // rmin squared is out
            acc   <= err_t'(quarter) + err_t'(prod[2*RAD_BITS-1:0]);
            phase <= 3'd5;
          end
          3'd5: begin
            acc   <= acc - err_t'(prod);       // minus rx2*rmin
            py0   <= err_t'(prod) <<< 1;       // 2*rx2*rmin
            phase <= 3'd6;
          end
          3'd6: begin
            p0         <= acc;
            setup_done <= 1'b1;
            phase      <= 3'd0;
          end
          default: begin
            phase <= 3'd0;  // idle until next start
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/ellipse_control.sv
// ellipse rasterizer control FSM
// latches a run command, picks the centre-point path for zero radii,
// launches setup and stepping for each half, swaps centre and radii
// between halves, and drives busy and the one-shot complete flag
`default_nettype none

module ellipse_control (
  input  logic                clk,
  input  logic                reset,
  input  logic                step,
  input  logic                run,
  input  logic [1:0]          quadrant,
  input  ellipse_pkg::coord_t xc,
  input  ellipse_pkg::coord_t yc,
  input  ellipse_pkg::coord_t xr,
  input  ellipse_pkg::coord_t yr,
  input  logic                setup_done,
  input  logic                half_done,
  output logic                start_setup,
  output logic                start_arc,
  output logic                point_valid,
  output logic                half,
  output logic                busy_reg,
  output logic                ellipse_complete,
  output logic [1:0]          quad,
  output ellipse_pkg::coord_t cx,
  output ellipse_pkg::coord_t cy,
  output ellipse_pkg::coord_t rmaj,
  output ellipse_pkg::coord_t rmin
);
  import ellipse_pkg::*;

  ctrl_state_t state;

  assign point_valid = (state == point);              // mapper takes the centre this cycle
  assign start_arc   = (state == setup) && setup_done; // stepper loads as setup finishes

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state            <= idle;
      start_setup      <= 1'b0;
      half             <= 1'b0;
      busy_reg         <= 1'b0;
      ellipse_complete <= 1'b0;
      quad             <= 2'd0;
      cx               <= '0;
      cy               <= '0;
      rmaj             <= '0;
      rmin             <= '0;
    end else if (step) begin
      start_setup      <= 1'b0;  // single step pulse
      ellipse_complete <= 1'b0;  // single step pulse
      case (state)
        idle: begin
          if (run) begin
            quad     <= quadrant;  // command latch
            cx       <= xc;
            cy       <= yc;
            rmaj     <= xr;
            rmin     <= yr;
            half     <= 1'b0;
            busy_reg <= 1'b1;
            if (xr == '0 && yr == '0) begin
              state <= point;      // nothing to rasterize, just the centre
            end else begin
              start_setup <= 1'b1;
              state       <= setup;
            end
          end
        end
        point: begin
          state <= done;  // centre registered by the mapper on this step
        end
        setup: begin
          if (setup_done) state <= arc;
        end
        arc: begin
          if (half_done) state <= flat;
        end
        flat: begin
          if (half) begin
            state <= done;
          end else begin
            // second half steps along the other axis
            cx          <= cy;
            cy          <= cx;
            rmaj        <= rmin;
            rmin        <= rmaj;
            half        <= 1'b1;
            start_setup <= 1'b1;
            state       <= setup;
          end
        end
        done: begin
          ellipse_complete <= 1'b1;
          busy_reg         <= 1'b0;  // top keeps busy up while run is held
          state            <= idle;
        end
      endcase
    end
  end

  // complete never covers two process steps
  complete_one_shot: assert property (@(posedge clk) disable iff (reset)
    ellipse_complete && step |=> !ellipse_complete);

  // setup is launched only from idle or at the half swap
  setup_on_entry: assert property (@(posedge clk) disable iff (reset)
    $rose(start_setup) |-> (state == setup) && ($past(state) inside {idle, flat}));

endmodule

`default_nettype wire

// File: verilog/ellipse_pkg.sv
// ellipse rasterizer shared definitions
// coordinate, radius, square and error widths, their vector types
// and the encoding of the control FSM
`default_nettype none

package ellipse_pkg;

  localparam int COORD_BITS = 12;              // signed screen coordinate, -2048..2047
  localparam int RAD_BITS   = COORD_BITS - 1;  // radius is a magnitude, sign bit dropped

  // screen coordinate, also used for centres, radii and local offsets
  typedef logic signed [COORD_BITS-1:0] coord_t;

  // multiplier operand a, one radius magnitude
  typedef logic [RAD_BITS-1:0] rad_t;

  // squared radius, also multiplier operand b
  typedef logic [2*RAD_BITS-1:0] sq_t;

  // full multiplier result, radius times squared radius
  typedef logic [3*RAD_BITS-1:0] prod_t;

  // decision term and slope accumulators, two guard bits over prod_t
  typedef logic signed [3*RAD_BITS+1:0] err_t;

  // control sequence of one command
  typedef enum logic [2:0] {
    idle,   // waiting for run
    point,  // zero radii, present the centre once
    setup,  // squared radii and initial error terms in progress
    arc,    // stepper walks the arc and its flat edge
    flat,   // flat edge closed, swap to second half or finish
    done    // one-shot complete, back to idle
  } ctrl_state_t;

endpackage

`default_nettype wire
